//--- design/npc_pkg.sv
`default_nettype none

package npc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Memory and bus geometry.
    //////////////////////////////////////////////////////////////////////

    localparam int MEM_WORDS = 1024;
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = DATA_W / 8;
    localparam int LEN_W     = 8;
    localparam int IDX_W     = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // Numeric order follows severity, so merging can compare values.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_AR,
        BR_R,
        BR_AW,
        BR_W,
        BR_B
    } bridge_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_BEAT
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    //////////////////////////////////////////////////////////////////////
    // Burst check shared by both RAM channel engines.
    //////////////////////////////////////////////////////////////////////

    function automatic resp_e burst_resp(
        input logic [ADDR_W-1:0] addr,
        input logic [LEN_W-1:0]  len,
        input burst_e            burst
    );
        logic [ADDR_W-2:0] first_word;
        logic [ADDR_W-2:0] last_word;
        first_word = (ADDR_W-1)'(addr[ADDR_W-1:2]);
        last_word  = first_word;
        if (burst == BURST_INCR) begin
            last_word = first_word + (ADDR_W-1)'(len);
        end
        // WRAP and the reserved encoding.
        if (burst != BURST_FIXED && burst != BURST_INCR) begin
            return RESP_SLVERR;
        end
        if (last_word >= (ADDR_W-1)'(MEM_WORDS)) begin
            return RESP_DECERR;
        end
        return RESP_OKAY;
    endfunction

endpackage

`default_nettype wire

//--- design/axi_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_if;
    import npc_pkg::*;

    // Read address.
    logic [ADDR_W-1:0] araddr;
    logic [LEN_W-1:0]  arlen;
    burst_e            arburst;
    logic              arvalid;
    logic              arready;

    // Write address.
    logic [ADDR_W-1:0] awaddr;
    logic [LEN_W-1:0]  awlen;
    burst_e            awburst;
    logic              awvalid;
    logic              awready;

    // Write data.
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wlast;
    logic              wvalid;
    logic              wready;

    // Read data.
    logic [DATA_W-1:0] rdata;
    resp_e             rresp;
    logic              rlast;
    logic              rvalid;
    logic              rready;

    // Write response.
    resp_e             bresp;
    logic              bvalid;
    logic              bready;

    modport master (
        output araddr, arlen, arburst, arvalid,
        input  arready,
        output awaddr, awlen, awburst, awvalid,
        input  awready,
        output wdata, wstrb, wlast, wvalid,
        input  wready,
        input  rdata, rresp, rlast, rvalid,
        output rready,
        input  bresp, bvalid,
        output bready
    );

    modport slave (
        input  araddr, arlen, arburst, arvalid,
        output arready,
        input  awaddr, awlen, awburst, awvalid,
        output awready,
        input  wdata, wstrb, wlast, wvalid,
        output wready,
        output rdata, rresp, rlast, rvalid,
        input  rready,
        output bresp, bvalid,
        input  bready
    );

endinterface

`default_nettype wire

//--- design/npc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module npc_bridge (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       cmd_start,
    input  logic                       cmd_write,
    input  logic [npc_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [npc_pkg::LEN_W-1:0]  cmd_len,
    input  npc_pkg::burst_e            cmd_burst,
    input  logic [npc_pkg::DATA_W-1:0] wbeat_data,
    input  logic [npc_pkg::STRB_W-1:0] wbeat_strb,
    output logic                       wbeat_take,
    input  logic                       rbeat_ready,
    output logic                       rbeat_valid,
    output logic [npc_pkg::DATA_W-1:0] rbeat_data,
    output logic                       busy,
    output logic                       cmd_done,
    output npc_pkg::resp_e             cmd_resp,
    axi_if.master                      axi
);
    import npc_pkg::*;

    bridge_state_e     state_q;
    logic [ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]  len_q;
    burst_e            burst_q;
    logic [LEN_W-1:0]  beat_q;
    resp_e             worst_q;
    resp_e             rd_merged;
    logic              w_fire;
    logic              r_fire;

    assign w_fire    = axi.wvalid && axi.wready;
    assign r_fire    = axi.rvalid && axi.rready;
    // Worst of the responses so far and the current beat.
    assign rd_merged = (axi.rresp > worst_q) ? axi.rresp : worst_q;

    //////////////////////////////////////////////////////////////////////
    // Channel outputs.
    //////////////////////////////////////////////////////////////////////

    assign axi.arvalid = (state_q == BR_AR);
    assign axi.araddr  = addr_q;
    assign axi.arlen   = len_q;
    assign axi.arburst = burst_q;

    assign axi.awvalid = (state_q == BR_AW);
    assign axi.awaddr  = addr_q;
    assign axi.awlen   = len_q;
    assign axi.awburst = burst_q;

    // Write data comes straight from the source, pulled by wbeat_take.
    assign axi.wvalid  = (state_q == BR_W);
    assign axi.wdata   = wbeat_data;
    assign axi.wstrb   = wbeat_strb;
    assign axi.wlast   = (beat_q == len_q);
    assign wbeat_take  = w_fire;

    assign axi.rready  = rbeat_ready;
    assign rbeat_valid = r_fire;
    assign rbeat_data  = axi.rdata;

    assign axi.bready  = (state_q == BR_B);
    assign busy        = (state_q != BR_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Command FSM.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q  <= BR_IDLE;
            beat_q   <= '0;
            worst_q  <= RESP_OKAY;
            cmd_done <= 1'b0;
            cmd_resp <= RESP_OKAY;
        end else begin
            cmd_done <= 1'b0;
            case (state_q)
                BR_IDLE: begin
                    if (cmd_start) begin
                        state_q <= cmd_write ? BR_AW : BR_AR;
                        beat_q  <= '0;
                        worst_q <= RESP_OKAY;
                    end
                end
                BR_AR: begin
                    if (axi.arready) begin
                        state_q <= BR_R;
                    end
                end
                BR_R: begin
                    if (r_fire) begin
                        worst_q <= rd_merged;
                        if (axi.rlast) begin
                            state_q  <= BR_IDLE;
                            cmd_done <= 1'b1;
                            cmd_resp <= rd_merged;
                        end
                    end
                end
                BR_AW: begin
                    if (axi.awready) begin
                        state_q <= BR_W;
                    end
                end
                BR_W: begin
                    if (w_fire) begin
                        beat_q <= beat_q + 1'b1;
                        if (axi.wlast) begin
                            state_q <= BR_B;
                        end
                    end
                end
                BR_B: begin
                    if (axi.bvalid) begin
                        state_q  <= BR_IDLE;
                        cmd_done <= 1'b1;
                        cmd_resp <= axi.bresp;
                    end
                end
                default: state_q <= BR_IDLE;
            endcase
        end
    end

    // Command fields.
    always_ff @(posedge clock) begin
        if (state_q == BR_IDLE && cmd_start) begin
            addr_q  <= cmd_addr;
            len_q   <= cmd_len;
            burst_q <= cmd_burst;
        end
    end

    a_ar_hold: assert property (@(posedge clock) disable iff (rst)
        axi.arvalid && !axi.arready |=> axi.arvalid);
    a_aw_hold: assert property (@(posedge clock) disable iff (rst)
        axi.awvalid && !axi.awready |=> axi.awvalid);

endmodule

`default_nettype wire

//--- design/axi_ram_read.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_read (
    input  logic                       clock,
    input  logic                       rst,
    axi_if.slave                       axi,
    output logic [npc_pkg::IDX_W-1:0]  rd_index,
    input  logic [npc_pkg::DATA_W-1:0] rd_word
);
    import npc_pkg::*;

    rd_state_e        state_q;
    logic [IDX_W-1:0] idx_q;
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] cnt_q;
    burst_e           burst_q;
    resp_e            resp_q;
    logic             rlast_q;
    logic             ar_fire;
    logic             r_fire;

    assign ar_fire     = axi.arvalid && axi.arready;
    assign r_fire      = axi.rvalid && axi.rready;

    assign axi.arready = (state_q == RD_IDLE);
    assign axi.rvalid  = (state_q == RD_BEAT);
    assign axi.rlast   = rlast_q;
    assign axi.rresp   = resp_q;
    // Errored bursts read back as zero.
    assign axi.rdata   = (resp_q == RESP_OKAY) ? rd_word : '0;
    assign rd_index    = idx_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= RD_IDLE;
            rlast_q <= 1'b0;
            cnt_q   <= '0;
            resp_q  <= RESP_OKAY;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state_q <= RD_BEAT;
                        cnt_q   <= '0;
                        rlast_q <= (axi.arlen == '0);
                        resp_q  <= burst_resp(axi.araddr, axi.arlen, axi.arburst);
                    end
                end
                RD_BEAT: begin
                    if (r_fire) begin
                        if (rlast_q) begin
                            state_q <= RD_IDLE;
                            rlast_q <= 1'b0;
                        end else begin
                            cnt_q   <= cnt_q + 1'b1;
                            rlast_q <= (cnt_q + 1'b1 == len_q);
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // FIXED holds the index, INCR steps it per beat.
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            idx_q   <= axi.araddr[IDX_W+1:2];
            len_q   <= axi.arlen;
            burst_q <= axi.arburst;
        end else if (r_fire && !rlast_q && burst_q == BURST_INCR) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    a_rlast_valid: assert property (@(posedge clock) disable iff (rst)
        axi.rlast |-> axi.rvalid);

endmodule

`default_nettype wire

//--- design/axi_ram_write.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_write (
    input  logic                       clock,
    input  logic                       rst,
    axi_if.slave                       axi,
    output logic                       wr_en,
    output logic [npc_pkg::IDX_W-1:0]  wr_index,
    output logic [npc_pkg::DATA_W-1:0] wr_data,
    output logic [npc_pkg::STRB_W-1:0] wr_strb
);
    import npc_pkg::*;

    wr_state_e        state_q;
    logic [IDX_W-1:0] idx_q;
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] cnt_q;
    burst_e           burst_q;
    resp_e            resp_q;
    logic             aw_fire;
    logic             w_fire;

    assign aw_fire     = axi.awvalid && axi.awready;
    assign w_fire      = axi.wvalid && axi.wready;

    assign axi.awready = (state_q == WR_IDLE);
    assign axi.wready  = (state_q == WR_DATA);
    assign axi.bvalid  = (state_q == WR_RESP);
    assign axi.bresp   = resp_q;

    // No array write at all once the burst has failed its check.
    assign wr_en       = w_fire && (resp_q == RESP_OKAY);
    assign wr_index    = idx_q;
    assign wr_data     = axi.wdata;
    assign wr_strb     = axi.wstrb;

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= WR_IDLE;
            cnt_q   <= '0;
            resp_q  <= RESP_OKAY;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (aw_fire) begin
                        state_q <= WR_DATA;
                        cnt_q   <= '0;
                        resp_q  <= burst_resp(axi.awaddr, axi.awlen, axi.awburst);
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (axi.wlast) begin
                            state_q <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (axi.bready) begin
                        state_q <= WR_IDLE;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire) begin
            idx_q   <= axi.awaddr[IDX_W+1:2];
            len_q   <= axi.awlen;
            burst_q <= axi.awburst;
        end else if (w_fire && burst_q == BURST_INCR) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // Master's wlast must agree with the length taken from AW.
    a_wlast_count: assert property (@(posedge clock) disable iff (rst)
        w_fire |-> (axi.wlast == (cnt_q == len_q)));

endmodule

`default_nettype wire

//--- design/npc_ram.sv
`timescale 1ns/1ps
`default_nettype none

module npc_ram (
    input  logic clock,
    input  logic rst,
    axi_if.slave axi
);
    import npc_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic [IDX_W-1:0]  rd_index;
    logic [DATA_W-1:0] rd_word;
    logic              wr_en;
    logic [IDX_W-1:0]  wr_index;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;

    //////////////////////////////////////////////////////////////////////
    // Storage array.
    //////////////////////////////////////////////////////////////////////

    assign rd_word = mem[rd_index];

    // Byte lanes with a low strobe keep their old contents.
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Channel engines.
    //////////////////////////////////////////////////////////////////////

    axi_ram_read rd0 (
        .clock    (clock),
        .rst      (rst),
        .axi      (axi),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

    axi_ram_write wr0 (
        .clock    (clock),
        .rst      (rst),
        .axi      (axi),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

endmodule

`default_nettype wire

//--- design/npc_top.sv
`timescale 1ns/1ps
`default_nettype none

module npc_top (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       cmd_start,
    input  logic                       cmd_write,
    input  logic [npc_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [npc_pkg::LEN_W-1:0]  cmd_len,
    input  npc_pkg::burst_e            cmd_burst,
    input  logic [npc_pkg::DATA_W-1:0] wbeat_data,
    input  logic [npc_pkg::STRB_W-1:0] wbeat_strb,
    output logic                       wbeat_take,
    input  logic                       rbeat_ready,
    output logic                       rbeat_valid,
    output logic [npc_pkg::DATA_W-1:0] rbeat_data,
    output logic                       busy,
    output logic                       cmd_done,
    output npc_pkg::resp_e             cmd_resp
);

    axi_if axi0 ();

    // Command side to AXI master.
    npc_bridge bridge0 (
        .clock       (clock),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_addr    (cmd_addr),
        .cmd_len     (cmd_len),
        .cmd_burst   (cmd_burst),
        .wbeat_data  (wbeat_data),
        .wbeat_strb  (wbeat_strb),
        .wbeat_take  (wbeat_take),
        .rbeat_ready (rbeat_ready),
        .rbeat_valid (rbeat_valid),
        .rbeat_data  (rbeat_data),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .cmd_resp    (cmd_resp),
        .axi         (axi0.master)
    );

    npc_ram ram0 (
        .clock (clock),
        .rst   (rst),
        .axi   (axi0.slave)
    );

endmodule

`default_nettype wire

//--- verif/npc_tests.svh
`ifndef NPC_TESTS_SVH
`define NPC_TESTS_SVH

// Write from wr_buf and strb_buf, then update the model.
task automatic write_burst(input int word, input int beats, input burst_e burst);
    run_command(1'b1, word, beats, burst, 1'b0);
    check_value("cmd_resp", 32'(done_resp), 32'(expect_resp(word, beats, burst)));
    check_value("wbeat_take count", beats_taken, beats);
    model_write(word, beats, burst);
endtask

// Errored reads must come back as zero.
task automatic read_burst(input int word, input int beats, input burst_e burst,
                          input logic random_ready);
    resp_e exp_resp;
    int    w;
    exp_resp = expect_resp(word, beats, burst);
    run_command(1'b0, word, beats, burst, random_ready);
    check_value("cmd_resp", 32'(done_resp), 32'(exp_resp));
    check_value("rbeat_valid count", rd_beats.size(), beats);
    w = word;
    for (int i = 0; i < beats; i++) begin
        check_value($sformatf("rbeat_data[%0d]", i), rd_beats[i],
                    (exp_resp == RESP_OKAY) ? ref_mem[w] : 32'h0);
        if (burst == BURST_INCR) begin
            w++;
        end
    end
endtask

task automatic fill_memory();
    for (int i = 0; i < 48; i++) begin
        wr_buf[i]   = fill_word(i);
        strb_buf[i] = '1;
    end
    write_burst(0, 48, BURST_INCR);
    for (int i = 0; i < 16; i++) begin
        wr_buf[i]   = fill_word(1008 + i);
        strb_buf[i] = '1;
    end
    write_burst(1008, 16, BURST_INCR);
endtask

task automatic single_beat_roundtrip();
    wr_buf[0]   = $urandom();
    strb_buf[0] = '1;
    write_burst(5, 1, BURST_INCR);
    read_burst(5, 1, BURST_INCR, 1'b0);
    check_value("rbeat_data", rd_beats[0], wr_buf[0]);
endtask

task automatic incr_partial_strobes();
    for (int i = 0; i < 8; i++) begin
        wr_buf[i]   = $urandom();
        strb_buf[i] = STRB_W'($urandom_range(0, (1 << STRB_W) - 1));
    end
    write_burst(8, 8, BURST_INCR);
    read_burst(8, 8, BURST_INCR, 1'b0);
endtask

task automatic fixed_burst();
    for (int i = 0; i < 4; i++) begin
        wr_buf[i]   = $urandom();
        strb_buf[i] = '1;
    end
    write_burst(20, 4, BURST_FIXED);
    read_burst(20, 4, BURST_FIXED, 1'b0);
    for (int i = 0; i < 4; i++) begin
        check_value($sformatf("rbeat_data[%0d]", i), rd_beats[i], wr_buf[3]);
    end
    // Neighbours of the FIXED address.
    read_burst(19, 3, BURST_INCR, 1'b0);
endtask

task automatic read_backpressure();
    read_burst(0, 16, BURST_INCR, 1'b1);
endtask

task automatic error_responses();
    for (int i = 0; i < 8; i++) begin
        wr_buf[i]   = $urandom();
        strb_buf[i] = '1;
    end
    write_burst(1020, 8, BURST_INCR);
    check_value("cmd_resp", 32'(done_resp), 32'(RESP_DECERR));
    read_burst(1020, 8, BURST_INCR, 1'b0);
    check_value("cmd_resp", 32'(done_resp), 32'(RESP_DECERR));
    read_burst(2000, 1, BURST_FIXED, 1'b0);
    check_value("cmd_resp", 32'(done_resp), 32'(RESP_DECERR));
    write_burst(24, 4, BURST_WRAP);
    check_value("cmd_resp", 32'(done_resp), 32'(RESP_SLVERR));
    read_burst(24, 4, BURST_WRAP, 1'b0);
    check_value("cmd_resp", 32'(done_resp), 32'(RESP_SLVERR));
    // Words near the failed bursts still hold their old data.
    read_burst(1008, 16, BURST_INCR, 1'b0);
    read_burst(16, 16, BURST_INCR, 1'b0);
endtask

`endif

//--- verif/npc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module npc_tb;
    import npc_pkg::*;

    localparam int PERIOD      = 20;
    localparam int SEED        = 13;
    localparam int RESET_CYC   = 4;
    localparam int MAX_BEATS   = 256;
    // Beats and commands over all tests, for the watchdog.
    localparam int TOTAL_BEATS = 166;
    localparam int TOTAL_CMDS  = 17;
    localparam int LIMIT_CYC   = TOTAL_BEATS * 8 + TOTAL_CMDS * 10 + RESET_CYC + 20;

    logic              clock;
    logic              rst;
    logic              cmd_start;
    logic              cmd_write;
    logic [ADDR_W-1:0] cmd_addr;
    logic [LEN_W-1:0]  cmd_len;
    burst_e            cmd_burst;
    logic [DATA_W-1:0] wbeat_data;
    logic [STRB_W-1:0] wbeat_strb;
    logic              wbeat_take;
    logic              rbeat_ready;
    logic              rbeat_valid;
    logic [DATA_W-1:0] rbeat_data;
    logic              busy;
    logic              cmd_done;
    resp_e             cmd_resp;

    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [DATA_W-1:0] wr_buf [MAX_BEATS];
    logic [STRB_W-1:0] strb_buf [MAX_BEATS];
    logic [DATA_W-1:0] rd_beats [$];
    resp_e             done_resp;
    int                beats_taken;

    npc_top dut0 (
        .clock       (clock),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_addr    (cmd_addr),
        .cmd_len     (cmd_len),
        .cmd_burst   (cmd_burst),
        .wbeat_data  (wbeat_data),
        .wbeat_strb  (wbeat_strb),
        .wbeat_take  (wbeat_take),
        .rbeat_ready (rbeat_ready),
        .rbeat_valid (rbeat_valid),
        .rbeat_data  (rbeat_data),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .cmd_resp    (cmd_resp)
    );

    always #(PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////
    // Failure reporting and checks.
    ////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%08h, expected 0x%08h",
                                    name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////////////////////////////////

    // Odd multiplier, so every word index gets its own value.
    function automatic logic [31:0] fill_word(input int w);
        return (w * 32'h0001_0003) ^ 32'hA5C3_0000;
    endfunction

    function automatic resp_e expect_resp(input int word, input int beats,
                                          input burst_e burst);
        int last;
        if (burst == BURST_WRAP) begin
            return RESP_SLVERR;
        end
        last = (burst == BURST_INCR) ? word + beats - 1 : word;
        if (last >= MEM_WORDS) begin
            return RESP_DECERR;
        end
        return RESP_OKAY;
    endfunction

    task automatic model_write(input int word, input int beats, input burst_e burst);
        int w;
        w = word;
        if (expect_resp(word, beats, burst) == RESP_OKAY) begin
            for (int i = 0; i < beats; i++) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (strb_buf[i][b]) begin
                        ref_mem[w][8*b +: 8] = wr_buf[i][8*b +: 8];
                    end
                end
                if (burst == BURST_INCR) begin
                    w++;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Command driver.
    ////////////////////////////////////////////////////////////////////

    // Inputs change on the falling edge, outputs are sampled 1 ns later.
    task automatic run_command(input logic write, input int word, input int beats,
                               input burst_e burst, input logic random_ready);
        logic finished;
        int   k;
        finished    = 1'b0;
        beats_taken = 0;
        rd_beats.delete();
        @(negedge clock);
        while (busy) begin
            @(negedge clock);
        end
        cmd_start = 1'b1;
        cmd_write = write;
        cmd_addr  = word * 4;
        cmd_len   = LEN_W'(beats - 1);
        cmd_burst = burst;
        while (!finished) begin
            k = (beats_taken < beats) ? beats_taken : beats - 1;
            wbeat_data  = wr_buf[k];
            wbeat_strb  = strb_buf[k];
            rbeat_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            #1;
            // Busy is low only in the start cycle and with cmd_done.
            check_value("busy", 32'(busy), 32'(!cmd_start && !cmd_done));
            if (wbeat_take) begin
                beats_taken++;
            end
            if (rbeat_valid) begin
                rd_beats.push_back(rbeat_data);
            end
            if (cmd_done) begin
                finished  = 1'b1;
                done_resp = cmd_resp;
            end
            @(negedge clock);
            cmd_start = 1'b0;
        end
    endtask

    `include "npc_tests.svh"

    initial begin
        #(LIMIT_CYC * PERIOD);
        stop_on_error("watchdog expired before the tests finished");
    end

    initial begin
        clock       = 1'b0;
        rst         = 1'b1;
        cmd_start   = 1'b0;
        cmd_write   = 1'b0;
        cmd_addr    = '0;
        cmd_len     = '0;
        cmd_burst   = BURST_INCR;
        wbeat_data  = '0;
        wbeat_strb  = '0;
        rbeat_ready = 1'b1;
        void'($urandom(SEED));
        repeat (RESET_CYC) @(negedge clock);
        rst = 1'b0;
        check_value("busy", 32'(busy), 32'h0);
        check_value("cmd_done", 32'(cmd_done), 32'h0);
        check_value("rbeat_valid", 32'(rbeat_valid), 32'h0);
        check_value("wbeat_take", 32'(wbeat_take), 32'h0);
        fill_memory();
        single_beat_roundtrip();
        incr_partial_strobes();
        fixed_burst();
        read_backpressure();
        error_responses();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verif
design/npc_pkg.sv
design/axi_if.sv
design/npc_bridge.sv
design/axi_ram_read.sv
design/axi_ram_write.sv
design/npc_ram.sv
design/npc_top.sv
verif/npc_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a $fatal gives a failing exit status.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module npc_tb -f verilog.f -o npc_sim \
    && ./obj_dir/npc_sim \
    || { echo "simulation failed" >&2; exit 1; }
